/* hw/dupPkg.sv */
`default_nettype none

package dupPkg;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      RXCSR  = 2'd0,
      RXDBUF = 2'd1,
      TXCSR  = 2'd2,
      TXDBUF = 2'd3
   } regSelT;

   // Bus master request, strobes are plain levels
   typedef struct packed {
      regSelT      sel;
      logic        rd;
      logic        wr;
      logic [15:0] wdata;
   } busReqT;

   ////////////////////////////////////////
   // Status words
   ////////////////////////////////////////

   // Receive status, bit 15 is the overrun flag
   typedef struct packed {
      logic       dataLate;
      logic [6:0] rsvd14to8;
      logic       rxDone;
      logic       rxIntEn;
      logic [5:0] rsvd5to0;
   } rxCsrT;

   // Transmit status, devInit is write only
   typedef struct packed {
      logic [6:0] rsvd15to9;
      logic       devInit;
      logic       txReady;
      logic       txIntEn;
      logic [5:0] rsvd5to0;
   } txCsrT;

   // One bus word seen as either channel's CSR
   typedef union packed {
      rxCsrT rx;
      txCsrT tx;
   } csrWordT;

   // Per channel interrupt status
   typedef struct packed {
      logic intr;
      logic priact;
   } intrStatT;

   // Default vectors and character time
   localparam logic [8:0] DEF_RX_VECTOR   = 9'o300;
   localparam logic [8:0] DEF_TX_VECTOR   = 9'o304;
   localparam int         DEF_CHAR_CYCLES = 16;

endpackage

`default_nettype wire

/* hw/dupIntr.sv */
`timescale 1ns/1ps
`default_nettype none

module dupIntr (
   input  logic clk,
   input  logic rst,
   input  logic init,     // Device init, back to idle
   input  logic vect,     // Vector acknowledge for this channel
   input  logic statRw,   // Channel CSR being accessed
   input  logic trig,     // Interrupt trigger pulse
   input  logic secinh,   // Secondary inhibit
   output logic priact,
   output logic intr
);

   ////////////////////////////////////////
   // States
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      stIdle     = 3'd0,
      stActive   = 3'd1,
      stVectRead = 3'd2,
      stWait     = 3'd3,
      stDone     = 3'd4
   } stateT;

   stateT state;

   ////////////////////////////////////////
   // Interrupt FSM
   ////////////////////////////////////////

   // Triggers seen outside idle are dropped
   // Retrigger only after a full CSR access
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= stIdle;
      end
      else if (init)
      begin
         state <= stIdle;
      end
      else
      begin
         case (state)
            // Waiting for a trigger
            stIdle:
            begin
               if (trig)
                  state <= stActive;
            end
            // Request up, waiting for an uninhibited acknowledge
            stActive:
            begin
               if (vect && !secinh)
                  state <= stVectRead;
            end
            // Vector taken, wait for acknowledge release
            stVectRead:
            begin
               if (!vect)
                  state <= stWait;
            end
            // Waiting for software to touch the CSR
            stWait:
            begin
               if (statRw)
                  state <= stDone;
            end
            // CSR access in progress
            stDone:
            begin
               if (!statRw)
                  state <= stIdle;
            end
            default:
            begin
               state <= stIdle;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   // Request drops once the vector has been seen
   assign intr = (state == stActive);

   // Busy from trigger until CSR access released
   assign priact = (state != stIdle);

endmodule

`default_nettype wire

/* hw/dupRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module dupRegs
   import dupPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  busReqT      busReq,
   output logic [15:0] rdata,
   input  logic        charIn,
   input  logic [7:0]  rxData,
   input  logic        txDoneP,
   output logic        startTx,
   output logic [7:0]  txData,
   output logic        rxTrig,
   output logic        txTrig,
   output logic        rxStatRw,
   output logic        txStatRw,
   output logic        devInit
);

   csrWordT    wrWord;
   csrWordT    rdWord;
   logic       rdQ;
   logic       rdFirst;
   logic       rxWrCsr;
   logic       txWrCsr;
   logic       rxDone;
   logic       rxIntEn;
   logic       dataLate;
   logic       txReady;
   logic       txIntEn;
   logic [7:0] rxBuf;
   logic [7:0] txBuf;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   assign wrWord   = busReq.wdata;
   assign rdFirst  = busReq.rd && !rdQ;
   assign rxWrCsr  = busReq.wr && (busReq.sel == RXCSR);
   assign txWrCsr  = busReq.wr && (busReq.sel == TXCSR);
   assign rxStatRw = (busReq.rd || busReq.wr) && (busReq.sel == RXCSR);
   assign txStatRw = (busReq.rd || busReq.wr) && (busReq.sel == TXCSR);
   assign devInit  = txWrCsr && wrWord.tx.devInit;

   // Launch only when the transmitter is free
   assign startTx = busReq.wr && (busReq.sel == TXDBUF) && txReady;
   assign txData  = busReq.wdata[7:0];

   // Read mux
   always_comb
   begin
      rdWord = '0;
      case (busReq.sel)
         RXCSR:
         begin
            rdWord.rx.dataLate = dataLate;
            rdWord.rx.rxDone   = rxDone;
            rdWord.rx.rxIntEn  = rxIntEn;
         end
         RXDBUF:  rdWord = {8'h00, rxBuf};
         TXCSR:
         begin
            rdWord.tx.txReady = txReady;
            rdWord.tx.txIntEn = txIntEn;
         end
         default: rdWord = {8'h00, txBuf};
      endcase
      rdata = busReq.rd ? rdWord : 16'h0000;
   end

   ////////////////////////////////////////
   // CSR bits and triggers
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdQ      <= 1'b0;
         rxDone   <= 1'b0;
         rxIntEn  <= 1'b0;
         dataLate <= 1'b0;
         txReady  <= 1'b1;
         txIntEn  <= 1'b0;
         rxTrig   <= 1'b0;
         txTrig   <= 1'b0;
      end
      else
      begin
         rdQ    <= busReq.rd;
         rxTrig <= 1'b0;
         txTrig <= 1'b0;
         if (devInit)
         begin
            rxDone   <= 1'b0;
            rxIntEn  <= 1'b0;
            dataLate <= 1'b0;
            txReady  <= 1'b1;
            txIntEn  <= 1'b0;
         end
         else
         begin
            if (rxWrCsr)
               rxIntEn <= wrWord.rx.rxIntEn;
            if (txWrCsr)
               txIntEn <= wrWord.tx.txIntEn;
            // Read side effects on first edge of rd
            if (rdFirst && (busReq.sel == RXDBUF))
               rxDone <= 1'b0;
            if (rdFirst && (busReq.sel == RXCSR))
               dataLate <= 1'b0;
            // New character wins over a read clear
            if (charIn)
            begin
               rxDone <= 1'b1;
               rxTrig <= rxIntEn;
               if (rxDone)
                  dataLate <= 1'b1;
            end
            if (startTx)
               txReady <= 1'b0;
            if (txDoneP)
            begin
               txReady <= 1'b1;
               txTrig  <= txIntEn;
            end
            // Enabling with the transmitter idle interrupts at once
            if (txWrCsr && wrWord.tx.txIntEn && !txIntEn && txReady)
               txTrig <= 1'b1;
         end
      end
   end

   // Data buffers
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxBuf <= 8'h00;
         txBuf <= 8'h00;
      end
      else if (devInit)
      begin
         rxBuf <= 8'h00;
         txBuf <= 8'h00;
      end
      else
      begin
         if (charIn)
            rxBuf <= rxData;
         if (startTx)
            txBuf <= busReq.wdata[7:0];
      end
   end

endmodule

`default_nettype wire

/* hw/dupLink.sv */
`timescale 1ns/1ps
`default_nettype none

module dupLink #(
   parameter int CHAR_CYCLES = 16
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       init,
   input  logic       startTx,
   input  logic [7:0] txData,
   output logic       charIn,
   output logic [7:0] rxData,
   output logic       txDoneP
);

   localparam int CW = $clog2(CHAR_CYCLES + 1);

   logic          busy;
   logic [CW-1:0] count;

   ////////////////////////////////////////
   // Character timer
   ////////////////////////////////////////

   // Count runs down from CHAR_CYCLES-1, both pulses on the edge after zero
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busy    <= 1'b0;
         count   <= '0;
         charIn  <= 1'b0;
         txDoneP <= 1'b0;
      end
      else
      begin
         charIn  <= 1'b0;
         txDoneP <= 1'b0;
         if (init)
         begin
            busy  <= 1'b0;
            count <= '0;
         end
         else if (startTx)
         begin
            busy  <= 1'b1;
            count <= CW'(CHAR_CYCLES - 1);
         end
         else if (busy)
         begin
            if (count == '0)
            begin
               busy    <= 1'b0;
               charIn  <= 1'b1;
               txDoneP <= 1'b1;
            end
            else
               count <= count - 1'b1;
         end
      end
   end

   // Character on the wire
   always_ff @(posedge clk)
   begin
      if (startTx)
         rxData <= txData;
   end

endmodule

`default_nettype wire

/* hw/dupVector.sv */
`timescale 1ns/1ps
`default_nettype none

module dupVector
   import dupPkg::*;
#(
   parameter logic [8:0] RX_VECTOR = DEF_RX_VECTOR,
   parameter logic [8:0] TX_VECTOR = DEF_TX_VECTOR
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       iack,
   input  intrStatT   rxStat,
   input  intrStatT   txStat,
   output logic       rxVect,
   output logic       txVect,
   output logic       txSecinh,
   output logic [8:0] vector
);

   logic iackQ;
   logic grantRx;
   logic grantTx;

   ////////////////////////////////////////
   // Grant
   ////////////////////////////////////////

   // Taken on the rising edge of iack, held until iack drops
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         iackQ   <= 1'b0;
         grantRx <= 1'b0;
         grantTx <= 1'b0;
      end
      else
      begin
         iackQ <= iack;
         if (!iack)
         begin
            grantRx <= 1'b0;
            grantTx <= 1'b0;
         end
         else if (!iackQ)
         begin
            // Receive outranks transmit
            grantRx <= rxStat.intr;
            grantTx <= !rxStat.intr && txStat.intr;
         end
      end
   end

   // Acknowledge only to the winner
   assign rxVect   = iack && grantRx;
   assign txVect   = iack && grantTx;
   assign txSecinh = rxStat.intr;

   always_comb
   begin
      if (iack && grantRx)
         vector = RX_VECTOR;
      else if (iack && grantTx)
         vector = TX_VECTOR;
      else
         vector = 9'o000;
   end

endmodule

`default_nettype wire

/* hw/dupTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dupTop
   import dupPkg::*;
#(
   parameter logic [8:0] RX_VECTOR   = DEF_RX_VECTOR,
   parameter logic [8:0] TX_VECTOR   = DEF_TX_VECTOR,
   parameter int         CHAR_CYCLES = DEF_CHAR_CYCLES
) (
   input  logic        clk,
   input  logic        rst,
   input  busReqT      busReq,
   input  logic        iack,
   output logic [15:0] rdata,
   output logic        irq,
   output logic [8:0]  vector,
   output intrStatT    rxStat,
   output intrStatT    txStat
);

   logic       startTx;
   logic [7:0] txData;
   logic       charIn;
   logic [7:0] rxData;
   logic       txDoneP;
   logic       rxTrig;
   logic       txTrig;
   logic       rxStatRw;
   logic       txStatRw;
   logic       devInit;
   logic       rxVect;
   logic       txVect;
   logic       txSecinh;

   ////////////////////////////////////////
   // Registers and loopback
   ////////////////////////////////////////

   dupRegs uRegs (
      .clk      (clk),
      .rst      (rst),
      .busReq   (busReq),
      .rdata    (rdata),
      .charIn   (charIn),
      .rxData   (rxData),
      .txDoneP  (txDoneP),
      .startTx  (startTx),
      .txData   (txData),
      .rxTrig   (rxTrig),
      .txTrig   (txTrig),
      .rxStatRw (rxStatRw),
      .txStatRw (txStatRw),
      .devInit  (devInit)
   );

   dupLink #(.CHAR_CYCLES(CHAR_CYCLES)) uLink (
      .clk     (clk),
      .rst     (rst),
      .init    (devInit),
      .startTx (startTx),
      .txData  (txData),
      .charIn  (charIn),
      .rxData  (rxData),
      .txDoneP (txDoneP)
   );

   ////////////////////////////////////////
   // Interrupt side
   ////////////////////////////////////////

   // Primary channel, never inhibited
   dupIntr uRxIntr (
      .clk    (clk),
      .rst    (rst),
      .init   (devInit),
      .vect   (rxVect),
      .statRw (rxStatRw),
      .trig   (rxTrig),
      .secinh (1'b0),
      .priact (rxStat.priact),
      .intr   (rxStat.intr)
   );

   // Secondary channel
   dupIntr uTxIntr (
      .clk    (clk),
      .rst    (rst),
      .init   (devInit),
      .vect   (txVect),
      .statRw (txStatRw),
      .trig   (txTrig),
      .secinh (txSecinh),
      .priact (txStat.priact),
      .intr   (txStat.intr)
   );

   dupVector #(
      .RX_VECTOR (RX_VECTOR),
      .TX_VECTOR (TX_VECTOR)
   ) uVector (
      .clk      (clk),
      .rst      (rst),
      .iack     (iack),
      .rxStat   (rxStat),
      .txStat   (txStat),
      .rxVect   (rxVect),
      .txVect   (txVect),
      .txSecinh (txSecinh),
      .vector   (vector)
   );

   assign irq = rxStat.intr | txStat.intr;

endmodule

`default_nettype wire

/* bench/dupTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dupTb
   import dupPkg::*;
();

   localparam int TIMEOUT = 64;

   logic        clk;
   logic        rst;
   busReqT      busReq;
   logic        iack;
   logic [15:0] rdata;
   logic        irq;
   logic [8:0]  vector;
   intrStatT    rxStat;
   intrStatT    txStat;

   logic [31:0] lcgState;
   int          cycles = 0;

   // Reference model state
   logic        mRxDone;
   logic        mRxIntEn;
   logic        mDataLate;
   logic        mTxReady;
   logic        mTxIntEn;
   logic [7:0]  mRxBuf;
   logic [7:0]  mTxBuf;
   logic [7:0]  mFlightChar;
   int          mLaunch;
   logic        mRxIntr;
   logic        mRxPri;
   logic        mTxIntr;
   logic        mTxPri;

   dupTop u_dut (
      .clk    (clk),
      .rst    (rst),
      .busReq (busReq),
      .iack   (iack),
      .rdata  (rdata),
      .irq    (irq),
      .vector (vector),
      .rxStat (rxStat),
      .txStat (txStat)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Free running cycle count, used to time the character
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
   end

   ////////////////////////////////////////
   // Failure reporting and compares
   ////////////////////////////////////////

   task automatic abortRun();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic failValue(input string msg);
      $display("FAIL %0t ns: %s", $time, msg);
      abortRun();
   endtask

   task automatic failTimeout(input string what);
      $display("Timed out waiting for %s", what);
      abortRun();
   endtask

   task automatic checkWord(input string what, input logic [15:0] got,
                            input logic [15:0] exp);
      if (got !== exp)
         failValue($sformatf("%s read %h, expected %h", what, got, exp));
   endtask

   task automatic checkVector(input string what, input logic [8:0] got,
                              input logic [8:0] exp);
      if (got !== exp)
         failValue($sformatf("%s is %o, expected %o", what, got, exp));
   endtask

   task automatic checkStat(input string what, input intrStatT got, input intrStatT exp);
      if (got !== exp)
         failValue($sformatf("%s intr=%b priact=%b, expected intr=%b priact=%b",
                             what, got.intr, got.priact, exp.intr, exp.priact));
   endtask

   task automatic checkFlag(input string what, input logic got, input logic exp);
      if (got !== exp)
         failValue($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // LCG, bits 23 to 16 as the character
   function automatic logic [7:0] nextChar();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[23:16];
   endfunction

   function automatic logic [15:0] expectRead(input regSelT sel);
      logic [15:0] w;
      w = 16'h0000;
      case (sel)
         RXCSR:
         begin
            w[15] = mDataLate;
            w[7]  = mRxDone;
            w[6]  = mRxIntEn;
         end
         RXDBUF:  w = {8'h00, mRxBuf};
         TXCSR:
         begin
            w[7] = mTxReady;
            w[6] = mTxIntEn;
         end
         default: w = {8'h00, mTxBuf};
      endcase
      return w;
   endfunction

   // Receive outranks transmit
   function automatic logic [8:0] expectVector();
      if (mRxIntr)
         return 9'o300;
      else if (mTxIntr)
         return 9'o304;
      return 9'o000;
   endfunction

   task automatic initModel();
      mRxDone   = 1'b0;
      mRxIntEn  = 1'b0;
      mDataLate = 1'b0;
      mTxReady  = 1'b1;
      mTxIntEn  = 1'b0;
      mRxBuf    = 8'h00;
      mTxBuf    = 8'h00;
      mRxIntr   = 1'b0;
      mRxPri    = 1'b0;
      mTxIntr   = 1'b0;
      mTxPri    = 1'b0;
   endtask

   // A trigger on a busy channel is lost
   task automatic triggerRx();
      if (!mRxPri)
      begin
         mRxIntr = 1'b1;
         mRxPri  = 1'b1;
      end
   endtask

   task automatic triggerTx();
      if (!mTxPri)
      begin
         mTxIntr = 1'b1;
         mTxPri  = 1'b1;
      end
   endtask

   // CSR access frees a channel only after its vector was taken
   task automatic releaseRx();
      if (mRxPri && !mRxIntr)
         mRxPri = 1'b0;
   endtask

   task automatic releaseTx();
      if (mTxPri && !mTxIntr)
         mTxPri = 1'b0;
   endtask

   task automatic writeEffects(input regSelT sel, input logic [15:0] data);
      case (sel)
         RXCSR:
         begin
            mRxIntEn = data[6];
            releaseRx();
         end
         TXCSR:
         begin
            if (data[8])
               initModel();
            else
            begin
               // Enable with transmitter idle interrupts at once
               if (data[6] && !mTxIntEn && mTxReady)
                  triggerTx();
               mTxIntEn = data[6];
               releaseTx();
            end
         end
         TXDBUF:
         begin
            if (mTxReady)
            begin
               mTxReady    = 1'b0;
               mFlightChar = data[7:0];
               mTxBuf      = data[7:0];
               mLaunch     = cycles;
            end
         end
         default:
         begin
         end
      endcase
   endtask

   task automatic readEffects(input regSelT sel);
      case (sel)
         RXDBUF:  mRxDone = 1'b0;
         RXCSR:
         begin
            mDataLate = 1'b0;
            releaseRx();
         end
         TXCSR:   releaseTx();
         default:
         begin
         end
      endcase
   endtask

   // Receive and transmit events of one character
   task automatic deliverChar();
      if (mRxDone)
         mDataLate = 1'b1;
      mRxDone = 1'b1;
      mRxBuf  = mFlightChar;
      if (mRxIntEn)
         triggerRx();
      mTxReady = 1'b1;
      if (mTxIntEn)
         triggerTx();
   endtask

   task automatic grantEffects();
      if (mRxIntr)
         mRxIntr = 1'b0;
      else if (mTxIntr)
         mTxIntr = 1'b0;
   endtask

   ////////////////////////////////////////
   // Bus and interrupt tasks
   ////////////////////////////////////////

   task automatic busWrite(input regSelT sel, input logic [15:0] data);
      @(posedge clk);
      #1;
      busReq.sel   = sel;
      busReq.wdata = data;
      busReq.wr    = 1'b1;
      @(posedge clk);
      #1;
      busReq.wr = 1'b0;
      writeEffects(sel, data);
   endtask

   // Sample mid cycle, before the edge that applies read side effects
   task automatic busRead(input regSelT sel, output logic [15:0] got);
      @(posedge clk);
      #1;
      busReq.sel = sel;
      busReq.rd  = 1'b1;
      #4;
      got = rdata;
      @(posedge clk);
      #1;
      busReq.rd = 1'b0;
   endtask

   task automatic readAndCheck(input regSelT sel, input string what);
      logic [15:0] got;
      logic [15:0] exp;
      exp = expectRead(sel);
      busRead(sel, got);
      checkWord(what, got, exp);
      readEffects(sel);
   endtask

   task automatic intrAck(output logic [8:0] vec);
      int n;
      n = 0;
      while (irq !== 1'b1)
      begin
         if (n == TIMEOUT)
            failTimeout("irq");
         @(posedge clk);
         #1;
         n++;
      end
      @(posedge clk);
      #1;
      iack = 1'b1;
      n    = 0;
      vec  = 9'o000;
      // Grant is registered on the first edge with iack
      while (vec == 9'o000)
      begin
         if (n == TIMEOUT)
            failTimeout("a granted vector");
         @(posedge clk);
         #1;
         vec = vector;
         n++;
      end
      // Hold one more edge so the channel sees vect
      @(posedge clk);
      #1;
      iack = 1'b0;
   endtask

   task automatic ackAndCheck(input string what);
      logic [8:0] got;
      logic [8:0] exp;
      exp = expectVector();
      intrAck(got);
      checkVector(what, got, exp);
      grantEffects();
   endtask

   task automatic waitChar();
      int n;
      n = 0;
      while (cycles < mLaunch + DEF_CHAR_CYCLES + 2)
      begin
         if (n == 4 * DEF_CHAR_CYCLES)
            failTimeout("character delivery");
         @(posedge clk);
         #1;
         n++;
      end
      deliverChar();
   endtask

   // One settle edge, then irq and both channels against the model
   task automatic checkState();
      intrStatT exp;
      @(posedge clk);
      #1;
      checkFlag("irq", irq, mRxIntr | mTxIntr);
      exp.intr   = mRxIntr;
      exp.priact = mRxPri;
      checkStat("rxStat", rxStat, exp);
      exp.intr   = mTxIntr;
      exp.priact = mTxPri;
      checkStat("txStat", txStat, exp);
   endtask

   // Fixed reset values
   task automatic checkResetState();
      logic [15:0] got;
      @(posedge clk);
      #1;
      checkFlag("irq at reset", irq, 1'b0);
      checkStat("rxStat at reset", rxStat, 2'b00);
      checkStat("txStat at reset", txStat, 2'b00);
      checkVector("vector at reset", vector, 9'o000);
      busRead(RXCSR, got);
      checkWord("RXCSR at reset", got, 16'h0000);
      busRead(TXCSR, got);
      checkWord("TXCSR at reset", got, 16'h0080);
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin
      logic [7:0] c;
      int         i;
      rst      = 1'b1;
      iack     = 1'b0;
      busReq   = '0;
      lcgState = 32'h6fe1bd24;
      initModel();
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset values
      checkResetState();
      checkState();

      // Loopback with enables clear, second write while busy is dropped
      for (i = 0; i < 4; i++)
      begin
         c = nextChar();
         busWrite(TXDBUF, {8'h00, c});
         readAndCheck(TXCSR, "TXCSR while busy");
         busWrite(TXDBUF, {8'h00, ~c});
         readAndCheck(TXDBUF, "TXDBUF after busy write");
         waitChar();
         checkState();
         readAndCheck(RXCSR, "RXCSR after loopback");
         readAndCheck(RXDBUF, "RXDBUF loopback char");
         readAndCheck(TXCSR, "TXCSR after loopback");
      end

      // Receive interrupt cycle, twice
      busWrite(RXCSR, 16'h0040);
      for (i = 0; i < 2; i++)
      begin
         c = nextChar();
         busWrite(TXDBUF, {8'h00, c});
         waitChar();
         checkState();
         ackAndCheck("receive vector");
         checkState();
         readAndCheck(RXDBUF, "RXDBUF receive char");
         checkState();
         readAndCheck(RXCSR, "RXCSR in service");
         checkState();
      end

      // Enabling transmit while ready interrupts first
      busWrite(TXCSR, 16'h0040);
      checkState();
      ackAndCheck("transmit enable vector");
      readAndCheck(TXCSR, "TXCSR in service");
      checkState();

      // Both channels pending from one character
      c = nextChar();
      busWrite(TXDBUF, {8'h00, c});
      waitChar();
      checkState();
      ackAndCheck("primary vector");
      checkState();
      ackAndCheck("secondary vector");
      checkState();
      readAndCheck(RXDBUF, "RXDBUF priority char");
      readAndCheck(RXCSR, "RXCSR after priority");
      readAndCheck(TXCSR, "TXCSR after priority");
      checkState();

      // Overrun
      busWrite(RXCSR, 16'h0000);
      busWrite(TXCSR, 16'h0000);
      for (i = 0; i < 2; i++)
      begin
         c = nextChar();
         busWrite(TXDBUF, {8'h00, c});
         waitChar();
      end
      checkState();
      readAndCheck(RXCSR, "RXCSR overrun");
      readAndCheck(RXCSR, "RXCSR after overrun read");
      readAndCheck(RXDBUF, "RXDBUF overrun char");

      // Device init with a request up and a character in flight
      busWrite(RXCSR, 16'h0040);
      c = nextChar();
      busWrite(TXDBUF, {8'h00, c});
      waitChar();
      checkState();
      c = nextChar();
      busWrite(TXDBUF, {8'h00, c});
      busWrite(TXCSR, 16'h0100);
      checkResetState();
      readAndCheck(RXDBUF, "RXDBUF after device init");
      for (i = 0; i < DEF_CHAR_CYCLES + 4; i++)
         @(posedge clk);
      checkState();
      readAndCheck(RXCSR, "RXCSR after aborted char");

      $display("Testbench passed");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (5000) @(posedge clk);
      $display("Simulation ran too long without finishing");
      abortRun();
   end

endmodule

`default_nettype wire

/* all.f */
hw/dupPkg.sv
hw/dupIntr.sv
hw/dupRegs.sv
hw/dupLink.sv
hw/dupVector.sv
hw/dupTop.sv
bench/dupTb.sv

/* Bender.yml */
package:
  name: dup11_intr

sources:
  - hw/dupPkg.sv
  - hw/dupIntr.sv
  - hw/dupRegs.sv
  - hw/dupLink.sv
  - hw/dupVector.sv
  - hw/dupTop.sv
  - target: test
    files:
      - bench/dupTb.sv
